// ==== common/armDp_config.svh ====
`ifndef ARM_DP_CONFIG_SVH
`define ARM_DP_CONFIG_SVH

// Datapath and register file sizing
`define DATA_WIDTH 32
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4

// Second-operand field of a data-processing command
`define OPERAND2_WIDTH 12

`endif

// ==== common/armDpPkg.sv ====
`include "armDp_config.svh"

package armDpPkg;

	typedef logic [`DATA_WIDTH-1:0] dataT;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;
	typedef logic [`OPERAND2_WIDTH-1:0] operand2T;

	// Data-processing opcodes in ARM encoding order
	typedef enum logic [3:0] {
		AND = 4'd0,
		EOR = 4'd1,
		SUB = 4'd2,
		RSB = 4'd3,
		ADD = 4'd4,
		ADC = 4'd5,
		SBC = 4'd6,
		RSC = 4'd7,
		TST = 4'd8,
		TEQ = 4'd9,
		CMP = 4'd10,
		CMN = 4'd11,
		ORR = 4'd12,
		MOV = 4'd13,
		BIC = 4'd14,
		MVN = 4'd15
	} aluOpT;

	typedef enum logic [1:0] {
		LSL = 2'd0,
		LSR = 2'd1,
		ASR = 2'd2,
		ROR = 2'd3
	} shiftTypeT;

	typedef struct packed {
		logic n; // Negative
		logic z; // Zero
		logic c; // Carry, inverted borrow on subtraction
		logic v; // Signed overflow
	} flagsT;

endpackage

// ==== common/operandIf.sv ====
`timescale 1ns/10ps

interface operandIf;
	import armDpPkg::*;

	logic valid;
	logic ready;
	aluOpT op;
	logic setFlags;
	regAddrT rd;
	dataT rnValue;
	dataT operand2Value; // Already shifted or rotated

	modport fetch (
		output valid, op, setFlags, rd, rnValue, operand2Value,
		input ready
	);

	modport exec (
		input valid, op, setFlags, rd, rnValue, operand2Value,
		output ready
	);

endinterface

// ==== source/regFile.sv ====
`timescale 1ns/10ps
`include "armDp_config.svh"

module regFile (
	input logic CLK,
	input logic CLR,
	input armDpPkg::regAddrT rdAddrA,
	input armDpPkg::regAddrT rdAddrB,
	output armDpPkg::dataT rdDataA,
	output armDpPkg::dataT rdDataB,
	input logic wrEn,
	input armDpPkg::regAddrT wrAddr,
	input armDpPkg::dataT wrData
);
	import armDpPkg::*;

	dataT regs [`REG_COUNT];

	always_ff @(posedge CLK or negedge CLR)
	begin
		if (!CLR)
			regs <= '{default: '0};
		else if (wrEn)
			regs[wrAddr] <= wrData;
	end

	// A read in the write cycle already sees the new value
	assign rdDataA = (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
	assign rdDataB = (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

// ==== source/shifterOperand.sv ====
`timescale 1ns/10ps
`include "armDp_config.svh"

module shifterOperand (
	input logic imm,
	input armDpPkg::operand2T operand2,
	input armDpPkg::dataT rmValue,
	output armDpPkg::dataT value
);
	import armDpPkg::*;

	logic [4:0] amount;
	shiftTypeT shiftType;
	dataT immValue;
	dataT regValue;

	function automatic dataT rotateRight(input dataT word, input logic [4:0] count);
		logic [2*`DATA_WIDTH-1:0] doubled;
		doubled = {word, word} >> count;
		return doubled[`DATA_WIDTH-1:0];
	endfunction

	// 8-bit constant rotated right by twice the 4-bit count
	assign immValue = rotateRight({{(`DATA_WIDTH-8){1'b0}}, operand2[7:0]},
		{operand2[11:8], 1'b0});

	assign amount = operand2[11:7];
	assign shiftType = shiftTypeT'(operand2[6:5]);

	// Amount of zero falls out as no shift for every type
	always_comb
	begin
		case (shiftType)
			LSL: regValue = rmValue << amount;
			LSR: regValue = rmValue >> amount;
			ASR: regValue = dataT'($signed(rmValue) >>> amount);
			ROR: regValue = rotateRight(rmValue, amount);
		endcase
	end

	assign value = imm ? immValue : regValue;

endmodule

// ==== source/operandFetch.sv ====
`timescale 1ns/10ps
`include "armDp_config.svh"

module operandFetch (
	input logic CLK,
	input logic CLR,
	input logic cmdValid,
	output logic cmdReady,
	input armDpPkg::aluOpT cmdOp,
	input logic cmdSetFlags,
	input armDpPkg::regAddrT cmdRd,
	input armDpPkg::regAddrT cmdRn,
	input logic cmdImm,
	input armDpPkg::operand2T cmdOperand2,
	output armDpPkg::regAddrT rnAddr,
	output armDpPkg::regAddrT rmAddr,
	input armDpPkg::dataT rnData,
	input armDpPkg::dataT rmData,
	operandIf.fetch opOut
);
	import armDpPkg::*;

	dataT operand2Value;
	logic accept;

	// Register reads straight from the command fields
	assign rnAddr = cmdRn;
	assign rmAddr = cmdOperand2[`REG_ADDR_WIDTH-1:0]; // Rm sits in the low bits

	shifterOperand shifter (
		.imm(cmdImm),
		.operand2(cmdOperand2),
		.rmValue(rmData),
		.value(operand2Value)
	);

	// Free slot, or the execute stage takes the held item this edge
	assign cmdReady = !opOut.valid || opOut.ready;
	assign accept = cmdValid && cmdReady;

	always_ff @(posedge CLK or negedge CLR)
	begin
		if (!CLR)
			opOut.valid <= 1'b0;
		else if (cmdReady)
			opOut.valid <= cmdValid;
	end

	always_ff @(posedge CLK)
	begin
		if (accept)
		begin
			opOut.op <= cmdOp;
			opOut.setFlags <= cmdSetFlags;
			opOut.rd <= cmdRd;
			opOut.rnValue <= rnData;
			opOut.operand2Value <= operand2Value;
		end
	end

endmodule

// ==== execute/aluCore.sv ====
`timescale 1ns/10ps
`include "armDp_config.svh"

module aluCore (
	input armDpPkg::aluOpT op,
	input armDpPkg::dataT rnValue,
	input armDpPkg::dataT operand2Value,
	input armDpPkg::flagsT flagsIn,
	output armDpPkg::dataT result,
	output armDpPkg::flagsT flagsOut,
	output logic writesRd
);
	import armDpPkg::*;

	dataT addA;
	dataT addB;
	logic addCin;
	logic arith;
	logic [`DATA_WIDTH:0] sum;
	logic overflow;

	// One adder for all eight arithmetic opcodes
	// Subtraction adds the complement, so carry out is the inverted borrow
	always_comb
	begin
		addA = rnValue;
		addB = operand2Value;
		addCin = 1'b0;
		arith = 1'b1;
		case (op)
			ADD, CMN: addCin = 1'b0;
			ADC: addCin = flagsIn.c;
			SUB, CMP:
			begin
				addB = ~operand2Value;
				addCin = 1'b1;
			end
			SBC:
			begin
				addB = ~operand2Value;
				addCin = flagsIn.c; // Minus NOT C
			end
			RSB:
			begin
				addA = operand2Value;
				addB = ~rnValue;
				addCin = 1'b1;
			end
			RSC:
			begin
				addA = operand2Value;
				addB = ~rnValue;
				addCin = flagsIn.c;
			end
			default: arith = 1'b0;
		endcase
	end

	assign sum = {1'b0, addA} + {1'b0, addB} + {{`DATA_WIDTH{1'b0}}, addCin};

	// Same-sign adder inputs with a sign flip on the output
	assign overflow = (addA[`DATA_WIDTH-1] == addB[`DATA_WIDTH-1])
		&& (sum[`DATA_WIDTH-1] != addA[`DATA_WIDTH-1]);

	always_comb
	begin
		case (op)
			AND, TST: result = rnValue & operand2Value;
			EOR, TEQ: result = rnValue ^ operand2Value;
			ORR: result = rnValue | operand2Value;
			MOV: result = operand2Value;
			BIC: result = rnValue & ~operand2Value;
			MVN: result = ~operand2Value;
			default: result = sum[`DATA_WIDTH-1:0];
		endcase
	end

	assign writesRd = !(op inside {TST, TEQ, CMP, CMN});

	assign flagsOut.n = result[`DATA_WIDTH-1];
	assign flagsOut.z = (result == '0);
	assign flagsOut.c = arith ? sum[`DATA_WIDTH] : flagsIn.c; // Logical ops keep C
	assign flagsOut.v = arith ? overflow : flagsIn.v;

endmodule

// ==== execute/executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
	input logic CLK,
	input logic CLR,
	operandIf.exec opIn,
	output logic wrEn,
	output armDpPkg::regAddrT wrAddr,
	output armDpPkg::dataT wrData,
	output logic rspValid,
	input logic rspReady,
	output armDpPkg::dataT rspResult,
	output armDpPkg::flagsT rspFlags
);
	import armDpPkg::*;

	flagsT flagsQ;
	flagsT aluFlags;
	dataT aluResult;
	logic writesRd;
	logic capture;

	aluCore alu (
		.op(opIn.op),
		.rnValue(opIn.rnValue),
		.operand2Value(opIn.operand2Value),
		.flagsIn(flagsQ),
		.result(aluResult),
		.flagsOut(aluFlags),
		.writesRd(writesRd)
	);

	assign opIn.ready = !rspValid || rspReady;
	assign capture = opIn.valid && opIn.ready;

	// Writeback lands on the capture edge
	assign wrEn = capture && writesRd;
	assign wrAddr = opIn.rd;
	assign wrData = aluResult;

	always_ff @(posedge CLK or negedge CLR)
	begin
		if (!CLR)
		begin
			rspValid <= 1'b0;
			flagsQ <= '0;
		end
		else
		begin
			if (capture)
				rspValid <= 1'b1;
			else if (rspReady)
				rspValid <= 1'b0;
			// Compare and test opcodes update flags regardless of S
			if (capture && (opIn.setFlags || !writesRd))
				flagsQ <= aluFlags;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (capture)
			rspResult <= aluResult;
	end

	// Flags only move on a capture, so they stay paired with the held result
	assign rspFlags = flagsQ;

endmodule

// ==== source/armDpTop.sv ====
`timescale 1ns/10ps

module armDpTop (
	input logic CLK,
	input logic CLR,
	input logic cmdValid,
	output logic cmdReady,
	input armDpPkg::aluOpT cmdOp,
	input logic cmdSetFlags,
	input armDpPkg::regAddrT cmdRd,
	input armDpPkg::regAddrT cmdRn,
	input logic cmdImm,
	input armDpPkg::operand2T cmdOperand2,
	output logic rspValid,
	input logic rspReady,
	output armDpPkg::dataT rspResult,
	output armDpPkg::flagsT rspFlags
);
	import armDpPkg::*;

	regAddrT rnAddr;
	regAddrT rmAddr;
	dataT rnData;
	dataT rmData;
	logic wrEn;
	regAddrT wrAddr;
	dataT wrData;

	operandIf opLink ();

	operandFetch fetch (
		.CLK(CLK),
		.CLR(CLR),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmdOp(cmdOp),
		.cmdSetFlags(cmdSetFlags),
		.cmdRd(cmdRd),
		.cmdRn(cmdRn),
		.cmdImm(cmdImm),
		.cmdOperand2(cmdOperand2),
		.rnAddr(rnAddr),
		.rmAddr(rmAddr),
		.rnData(rnData),
		.rmData(rmData),
		.opOut(opLink.fetch)
	);

	executeStage exec (
		.CLK(CLK),
		.CLR(CLR),
		.opIn(opLink.exec),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.rspResult(rspResult),
		.rspFlags(rspFlags)
	);

	regFile regs (
		.CLK(CLK),
		.CLR(CLR),
		.rdAddrA(rnAddr),
		.rdAddrB(rmAddr),
		.rdDataA(rnData),
		.rdDataB(rmData),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

endmodule

// ==== dv/armDpTb.sv ====
`timescale 1ns/10ps

module armDpTb;
	import armDpPkg::*;

	localparam int WAIT_LIMIT = 200;

	logic CLK;
	logic CLR;
	logic cmdValid;
	logic cmdReady;
	aluOpT cmdOp;
	logic cmdSetFlags;
	regAddrT cmdRd;
	regAddrT cmdRn;
	logic cmdImm;
	operand2T cmdOperand2;
	logic rspValid;
	logic rspReady;
	dataT rspResult;
	flagsT rspFlags;

	integer seed = 32'hceaf;
	dataT rnd;
	logic randomStall; // Random back-pressure on the response channel
	logic holding;
	dataT heldResult;
	flagsT heldFlags;
	dataT lastResult;
	flagsT lastFlags;

	// Reference model state
	dataT modelRegs [16];
	flagsT modelFlags;
	dataT expResultQ [$];
	flagsT expFlagsQ [$];

	armDpTop dut (.*);

	always #4 CLK = ~CLK;

	task automatic stopRun();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkData(input dataT actual, input dataT expected, input string name);
		if (actual !== expected)
		begin
			$display("FAIL at %0t: %s = %h, expected %h", $time, name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkFlags(input flagsT actual, input flagsT expected, input string name);
		if (actual !== expected)
		begin
			$display("FAIL at %0t: %s = %b, expected %b (nzcv)", $time, name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkBit(input logic actual, input logic expected, input string name);
		if (actual !== expected)
		begin
			$display("FAIL at %0t: %s = %b, expected %b", $time, name, actual, expected);
			stopRun();
		end
	endtask

	// Response side sampled on the falling edge where outputs are settled
	always @(negedge CLK)
	begin
		if (holding)
		begin
			if (!rspValid)
			begin
				$display("A held response was withdrawn before it was accepted");
				stopRun();
			end
			checkData(rspResult, heldResult, "rspResult while held");
			checkFlags(rspFlags, heldFlags, "rspFlags while held");
		end
		rspReady = randomStall ? (($random(seed) & 3) != 0) : 1'b1;
		holding = rspValid && !rspReady;
		heldResult = rspResult;
		heldFlags = rspFlags;
		if (rspValid && rspReady) // Transfer on the coming rising edge
		begin
			if (expResultQ.size() == 0)
			begin
				$display("The DUT sent a response with no command outstanding");
				stopRun();
			end
			checkData(rspResult, expResultQ.pop_front(), "rspResult");
			checkFlags(rspFlags, expFlagsQ.pop_front(), "rspFlags");
			lastResult = rspResult;
			lastFlags = rspFlags;
		end
	end

	function automatic dataT modelOperand2(input logic imm, input operand2T field, input dataT rm);
		dataT word;
		int steps;
		if (imm)
		begin
			word = {24'h0, field[7:0]};
			steps = 2 * field[11:8];
			repeat (steps) word = {word[0], word[31:1]};
		end
		else
		begin
			word = rm;
			steps = field[11:7];
			case (shiftTypeT'(field[6:5]))
				LSL: word = word << steps;
				LSR: word = word >> steps;
				ASR: repeat (steps) word = {word[31], word[31:1]};
				ROR: repeat (steps) word = {word[0], word[31:1]};
			endcase
		end
		return word;
	endfunction

	// Expected result and flags of one command
	task automatic runModel(input aluOpT op, input logic setFlags, input regAddrT rd,
		input dataT a, input dataT b);
		dataT res;
		dataT m;
		dataT s;
		logic [32:0] wide;
		logic arith;
		logic isSub;
		logic cin;
		logic isTest;
		flagsT next;
		res = '0;
		m = a;
		s = b;
		arith = 1'b1;
		isSub = 1'b0;
		cin = 1'b0;
		next = modelFlags;
		isTest = op inside {TST, TEQ, CMP, CMN};
		case (op)
			AND, TST: res = a & b;
			EOR, TEQ: res = a ^ b;
			ORR: res = a | b;
			MOV: res = b;
			BIC: res = a & ~b;
			MVN: res = ~b;
			ADC: cin = modelFlags.c;
			SUB, CMP: isSub = 1'b1;
			SBC: {isSub, cin} = {1'b1, !modelFlags.c}; // Borrow in is NOT C
			RSB: {isSub, m, s} = {1'b1, b, a};
			RSC: {isSub, cin, m, s} = {1'b1, !modelFlags.c, b, a};
			default: ; // ADD and CMN
		endcase
		if (op inside {AND, TST, EOR, TEQ, ORR, MOV, BIC, MVN})
			arith = 1'b0;
		if (arith && isSub)
		begin
			wide = {1'b0, m} - {1'b0, s} - {32'b0, cin};
			res = wide[31:0];
			next.c = !wide[32];
			next.v = (m[31] != s[31]) && (res[31] != m[31]);
		end
		else if (arith)
		begin
			wide = {1'b0, m} + {1'b0, s} + {32'b0, cin};
			res = wide[31:0];
			next.c = wide[32];
			next.v = (m[31] == s[31]) && (res[31] != m[31]);
		end
		next.n = res[31];
		next.z = (res == 32'h0);
		if (setFlags || isTest)
			modelFlags = next;
		if (!isTest)
			modelRegs[rd] = res;
		expResultQ.push_back(res);
		expFlagsQ.push_back(modelFlags);
	endtask

	task automatic sendCmd(input aluOpT op, input logic setFlags, input regAddrT rd,
		input regAddrT rn, input logic imm, input operand2T field);
		int waited;
		@(negedge CLK);
		cmdOp = op;
		cmdSetFlags = setFlags;
		cmdRd = rd;
		cmdRn = rn;
		cmdImm = imm;
		cmdOperand2 = field;
		cmdValid = 1'b1;
		waited = 0;
		#2;
		while (!cmdReady)
		begin
			@(negedge CLK);
			#2;
			waited++;
			if (waited > WAIT_LIMIT)
			begin
				$display("Timeout: the DUT never accepted a command");
				stopRun();
			end
		end
		@(posedge CLK); // Acceptance edge
	endtask

	task automatic issue(input aluOpT op, input logic setFlags, input regAddrT rd,
		input regAddrT rn, input logic imm, input operand2T field);
		runModel(op, setFlags, rd, modelRegs[rn], modelOperand2(imm, field, modelRegs[field[3:0]]));
		sendCmd(op, setFlags, rd, rn, imm, field);
	endtask

	task automatic drain();
		int waited;
		@(negedge CLK);
		cmdValid = 1'b0;
		waited = 0;
		while (expResultQ.size() != 0)
		begin
			@(negedge CLK);
			waited++;
			if (waited > WAIT_LIMIT)
			begin
				$display("Timeout: %0d responses never arrived", expResultQ.size());
				stopRun();
			end
		end
	endtask

	function automatic operand2T immField(input logic [3:0] rot, input logic [7:0] value);
		return {rot, value};
	endfunction

	function automatic operand2T regField(input logic [4:0] amount, input shiftTypeT kind,
		input regAddrT rm);
		return {amount, kind, 1'b0, rm};
	endfunction

	// Full word from four rotated bytes
	task automatic loadReg(input regAddrT rd, input dataT value);
		issue(MOV, 1'b0, rd, rd, 1'b1, immField(4'd0, value[7:0]));
		issue(ORR, 1'b0, rd, rd, 1'b1, immField(4'd12, value[15:8]));
		issue(ORR, 1'b0, rd, rd, 1'b1, immField(4'd8, value[23:16]));
		issue(ORR, 1'b0, rd, rd, 1'b1, immField(4'd4, value[31:24]));
	endtask

	task automatic testReset();
		checkBit(cmdReady, 1'b1, "cmdReady after reset");
		checkBit(rspValid, 1'b0, "rspValid after reset");
		issue(ADD, 1'b1, 4'd0, 4'd0, 1'b0, regField(5'd0, LSL, 4'd0));
		drain();
		checkData(lastResult, 32'h0, "rspResult of ADD r0, r0");
		checkFlags(lastFlags, 4'b0100, "rspFlags of ADD r0, r0");
	endtask

	task automatic testImmediates();
		for (int i = 0; i < 8; i++)
		begin
			rnd = $random(seed);
			issue(MOV, 1'b0, 4'd1, 4'd0, 1'b1, immField(rnd[3:0], rnd[15:8]));
			issue(MVN, 1'b0, 4'd2, 4'd0, 1'b1, immField(rnd[7:4], rnd[23:16]));
		end
		loadReg(4'd3, 32'hdeadbeef);
		rnd = $random(seed);
		loadReg(4'd4, rnd);
		drain();
	endtask

	task automatic testAllOpcodes();
		rnd = $random(seed);
		loadReg(4'd4, rnd);
		rnd = $random(seed);
		loadReg(4'd5, rnd);
		loadReg(4'd6, 32'h7fffffff);
		loadReg(4'd7, 32'h80000000);
		for (int i = 0; i < 16; i++)
		begin
			rnd = $random(seed);
			issue(aluOpT'(i), 1'b1, 4'd8, {2'b01, rnd[1:0]}, 1'b0,
				regField(rnd[12:8], shiftTypeT'(rnd[14:13]), {2'b01, rnd[17:16]}));
		end
		issue(ADD, 1'b1, 4'd9, 4'd7, 1'b0, regField(5'd0, LSL, 4'd7)); // Carry and overflow set
		for (int i = 0; i < 4; i++)
		begin
			issue(ADC, 1'b1, 4'd9, 4'd4, 1'b0, regField(5'd0, LSL, 4'd5));
			issue(SBC, 1'b1, 4'd10, 4'd5, 1'b0, regField(5'd0, LSL, 4'd4));
			issue(RSC, 1'b1, 4'd11, 4'd4, 1'b0, regField(5'd0, LSL, 4'd9));
		end
		issue(ADD, 1'b1, 4'd12, 4'd6, 1'b1, immField(4'd0, 8'd1));
		issue(SUB, 1'b1, 4'd12, 4'd7, 1'b1, immField(4'd0, 8'd1));
		issue(CMP, 1'b1, 4'd0, 4'd7, 1'b0, regField(5'd0, LSL, 4'd6));
		issue(RSB, 1'b1, 4'd12, 4'd6, 1'b0, regField(5'd0, LSL, 4'd7));
		drain();
	endtask

	task automatic testShifts();
		rnd = $random(seed);
		loadReg(4'd5, rnd | 32'h80000000); // Sign bit set for ASR
		for (int k = 0; k < 4; k++)
			for (int j = 0; j < 4; j++)
			begin
				rnd = $random(seed);
				issue(MOV, 1'b0, 4'd9, 4'd0, 1'b0, regField((j == 0) ? 5'd0 : (j == 1) ? 5'd31 :
					rnd[4:0], shiftTypeT'(k), 4'd5));
			end
		drain();
	endtask

	task automatic testFlagControl();
		rnd = $random(seed);
		loadReg(4'd11, rnd);
		rnd = $random(seed);
		loadReg(4'd12, rnd);
		for (int i = 8; i < 12; i++)
		begin
			issue(aluOpT'(i), 1'b0, 4'd11, 4'd12, 1'b0, regField(5'd0, LSL, 4'd11));
			issue(MOV, 1'b0, 4'd13, 4'd0, 1'b0, regField(5'd0, LSL, 4'd11)); // Reads Rd back
		end
		issue(CMP, 1'b1, 4'd0, 4'd11, 1'b0, regField(5'd0, LSL, 4'd12));
		issue(SUB, 1'b0, 4'd13, 4'd12, 1'b0, regField(5'd0, LSL, 4'd11));
		issue(ADD, 1'b0, 4'd13, 4'd13, 1'b0, regField(5'd0, LSL, 4'd11));
		issue(MVN, 1'b0, 4'd14, 4'd0, 1'b0, regField(5'd0, LSL, 4'd13));
		drain();
	endtask

	task automatic testBackPressure();
		regAddrT last;
		randomStall = 1'b1;
		rnd = $random(seed);
		loadReg(4'd13, rnd);
		rnd = $random(seed);
		loadReg(4'd14, rnd);
		last = 4'd14;
		for (int i = 0; i < 40; i++)
		begin
			rnd = $random(seed);
			issue(aluOpT'(rnd[3:0]), rnd[5], {3'b110, rnd[4]}, last, rnd[6], rnd[6] ?
				immField(rnd[11:8], rnd[19:12]) :
				regField(rnd[24:20], shiftTypeT'(rnd[26:25]), last));
			last = {3'b110, rnd[4]};
		end
		drain();
		randomStall = 1'b0;
	endtask

	initial
	begin
		CLK = 1'b0;
		CLR = 1'b0;
		cmdValid = 1'b0;
		cmdOp = AND;
		cmdSetFlags = 1'b0;
		cmdRd = '0;
		cmdRn = '0;
		cmdImm = 1'b0;
		cmdOperand2 = '0;
		rspReady = 1'b1;
		randomStall = 1'b0;
		holding = 1'b0;
		modelFlags = '0;
		foreach (modelRegs[i])
			modelRegs[i] = '0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		CLR = 1'b1;
		testReset();
		testImmediates();
		testAllOpcodes();
		testShifts();
		testFlagControl();
		testBackPressure();
		repeat (4) @(negedge CLK); // Room for a stray duplicate to show up
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== armDpTop.f ====
+incdir+common
common/armDpPkg.sv
common/operandIf.sv
source/regFile.sv
source/shifterOperand.sv
source/operandFetch.sv
execute/aluCore.sv
execute/executeStage.sv
source/armDpTop.sv
dv/armDpTb.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal --top-module armDpTb -f armDpTop.f \
		--Mdir obj_dir -o armDpSim
	./obj_dir/armDpSim

lint:
	verilator --lint-only --timing -Wall --top-module armDpTop -f armDpTop.f

clean:
	rm -rf obj_dir
